/* include/memset_settings.svh */
`ifndef MEMSET_SETTINGS_SVH
`define MEMSET_SETTINGS_SVH

// scratch memory geometry.
`define MEMSET_ADDR_BITS 8
`define MEMSET_DATA_BITS 8
`define MEMSET_MEM_DEPTH (1 << `MEMSET_ADDR_BITS)

// APB bus widths.
`define APB_ADDR_BITS 12
`define APB_DATA_BITS 32

// upper paddr bits that select the memory window (0x100 to 0x1ff).
`define MEMSET_WIN_PAGE 4'h1

`endif

/* logic/memset_pkg.sv */
`default_nettype none
`include "memset_settings.svh"

package memset_pkg;

	typedef struct packed {
		logic [`APB_ADDR_BITS-1:0] paddr;
		logic                      psel;
		logic                      penable;
		logic                      pwrite;
		logic [`APB_DATA_BITS-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [`APB_DATA_BITS-1:0] prdata;
		logic                      pready;
		logic                      pslverr;
	} apb_rsp_t;

	// one memset call.
	typedef struct packed {
		logic [`MEMSET_ADDR_BITS-1:0] base;
		logic [`MEMSET_ADDR_BITS:0]   count;  // 0 to 256 bytes.
		logic [`MEMSET_DATA_BITS-1:0] value;
	} fill_cmd_t;

	typedef struct packed {
		logic [`MEMSET_ADDR_BITS-1:0] addr;
		logic [`MEMSET_DATA_BITS-1:0] data;
		logic                         strobe;
	} mem_wr_t;

	typedef enum logic [1:0] {
		IDLE,
		FILL,
		DONE
	} fill_state_e;

	typedef enum logic [`APB_ADDR_BITS-1:0] {
		CTRL   = 'h000,
		STATUS = 'h004,
		BASE   = 'h008,
		COUNT  = 'h00c,
		VALUE  = 'h010,
		RESULT = 'h014
	} reg_sel_e;

endpackage

`default_nettype wire

/* logic/scratch_mem.sv */
`timescale 1ns/1ps
`default_nettype none
`include "memset_settings.svh"

module scratch_mem
	import memset_pkg::*;
(
	input  logic                         clk,
	input  mem_wr_t                      mem_wr,
	input  logic [`MEMSET_ADDR_BITS-1:0] win_addr,
	input  logic [`MEMSET_DATA_BITS-1:0] win_wdata,
	input  logic                         win_we,
	input  logic                         win_re,
	output logic [`MEMSET_DATA_BITS-1:0] win_rdata
);

	logic [`MEMSET_DATA_BITS-1:0] mem [`MEMSET_MEM_DEPTH];

	logic [`MEMSET_ADDR_BITS-1:0] port_addr;
	logic [`MEMSET_DATA_BITS-1:0] port_wdata;
	logic                         port_we;

	// the engine owns the single port whenever it strobes.
	always_comb
	begin
		if (mem_wr.strobe)
		begin
			port_addr  = mem_wr.addr;
			port_wdata = mem_wr.data;
			port_we    = 1'b1;
		end
		else
		begin
			port_addr  = win_addr;
			port_wdata = win_wdata;
			port_we    = win_we;
		end
	end

	always_ff @(posedge clk)
	begin
		if (port_we)
			mem[port_addr] <= port_wdata;
		else if (win_re)
			win_rdata <= mem[port_addr];  // registered read.
	end

endmodule

`default_nettype wire

/* logic/fill_engine.sv */
`timescale 1ns/1ps
`default_nettype none
`include "memset_settings.svh"

module fill_engine
	import memset_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      start,
	input  fill_cmd_t cmd,
	output logic      busy,
	output logic      finish,
	output mem_wr_t   mem_wr
);

	fill_state_e                  state;
	logic [`MEMSET_ADDR_BITS-1:0] addr_q;    // running byte address.
	logic [`MEMSET_ADDR_BITS:0]   remain_q;  // bytes still to write.
	logic [`MEMSET_DATA_BITS-1:0] value_q;
	logic                         launch;
	logic                         last_byte;

	assign launch    = (state == IDLE) & start;
	assign last_byte = (remain_q == {{`MEMSET_ADDR_BITS{1'b0}}, 1'b1});

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= IDLE;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (start)
						state <= (cmd.count == '0) ? DONE : FILL;  // empty fill skips ahead.
				end
				FILL:
				begin
					if (last_byte)
						state <= DONE;
				end
				DONE:
				begin
					state <= IDLE;
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	// address and count walk the range.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			addr_q   <= '0;
			remain_q <= '0;
		end
		else if (launch)
		begin
			addr_q   <= cmd.base;
			remain_q <= cmd.count;
		end
		else if (state == FILL)
		begin
			addr_q   <= addr_q + 1'b1;  // wraps at the memory depth.
			remain_q <= remain_q - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (launch)
			value_q <= cmd.value;
	end

	assign busy   = (state != IDLE);
	assign finish = (state == DONE);

	// one byte write per cycle in FILL.
	assign mem_wr.addr   = addr_q;
	assign mem_wr.data   = value_q;
	assign mem_wr.strobe = (state == FILL);

endmodule

`default_nettype wire

/* logic/memset_apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "memset_settings.svh"

module memset_apb_regs
	import memset_pkg::*;
(
	input  logic                         clk,
	input  logic                         reset,
	input  apb_req_t                     apb_req,
	output apb_rsp_t                     apb_rsp,
	input  logic                         busy,
	input  logic                         finish,
	output logic                         start,
	output fill_cmd_t                    cmd,
	output logic [`MEMSET_ADDR_BITS-1:0] win_addr,
	output logic [`MEMSET_DATA_BITS-1:0] win_wdata,
	output logic                         win_we,
	output logic                         win_re,
	input  logic [`MEMSET_DATA_BITS-1:0] win_rdata,
	output logic                         fill_done
);

	logic [`MEMSET_ADDR_BITS-1:0] base_q;
	logic [`MEMSET_ADDR_BITS:0]   count_q;
	logic [`MEMSET_DATA_BITS-1:0] value_q;
	logic [`MEMSET_ADDR_BITS-1:0] result_q;
	logic                         done_q;
	logic                         rd_wait_q;  // ram data valid this cycle.

	reg_sel_e                  sel;
	logic                      access;
	logic                      in_window;
	logic                      mapped;
	logic                      cfg_reg;  // locked while the engine runs.
	logic                      slv_err;
	logic                      win_read;
	logic                      wr_ok;
	logic [`APB_DATA_BITS-1:0] reg_rdata;

	assign access    = apb_req.psel & apb_req.penable;
	assign sel       = reg_sel_e'(apb_req.paddr);
	assign in_window = (apb_req.paddr[`APB_ADDR_BITS-1:`MEMSET_ADDR_BITS] == `MEMSET_WIN_PAGE);

	// register decode and read mux.
	always_comb
	begin
		reg_rdata = '0;
		mapped    = 1'b1;
		cfg_reg   = 1'b0;
		case (sel)
			CTRL:
			begin
				cfg_reg = 1'b1;
			end
			STATUS:
			begin
				reg_rdata = {{(`APB_DATA_BITS-2){1'b0}}, busy, done_q};
			end
			BASE:
			begin
				cfg_reg   = 1'b1;
				reg_rdata = {{(`APB_DATA_BITS-`MEMSET_ADDR_BITS){1'b0}}, base_q};
			end
			COUNT:
			begin
				cfg_reg   = 1'b1;
				reg_rdata = {{(`APB_DATA_BITS-`MEMSET_ADDR_BITS-1){1'b0}}, count_q};
			end
			VALUE:
			begin
				cfg_reg   = 1'b1;
				reg_rdata = {{(`APB_DATA_BITS-`MEMSET_DATA_BITS){1'b0}}, value_q};
			end
			RESULT:
			begin
				reg_rdata = {{(`APB_DATA_BITS-`MEMSET_ADDR_BITS){1'b0}}, result_q};
			end
			default:
			begin
				mapped = in_window;  // window page or a hole.
			end
		endcase
	end

	assign slv_err  = access & (~mapped | (busy & (in_window | (apb_req.pwrite & cfg_reg))));
	assign win_read = access & in_window & ~apb_req.pwrite & ~busy;
	assign wr_ok    = access & apb_req.pwrite & ~slv_err;

	// a window read holds pready low for one access cycle.
	assign apb_rsp.pready  = access & ~(win_read & ~rd_wait_q);
	assign apb_rsp.pslverr = slv_err;
	assign apb_rsp.prdata  = (access & ~apb_req.pwrite & ~slv_err) ?
		(in_window ? {{(`APB_DATA_BITS-`MEMSET_DATA_BITS){1'b0}}, win_rdata} : reg_rdata) :
		'0;

	assign win_addr  = apb_req.paddr[`MEMSET_ADDR_BITS-1:0];
	assign win_wdata = apb_req.pwdata[`MEMSET_DATA_BITS-1:0];
	assign win_we    = wr_ok & in_window;
	assign win_re    = win_read & ~rd_wait_q;

	assign start     = wr_ok & (sel == CTRL) & apb_req.pwdata[0];
	assign cmd       = '{base: base_q, count: count_q, value: value_q};
	assign fill_done = done_q;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			base_q    <= '0;
			count_q   <= '0;
			value_q   <= '0;
			result_q  <= '0;
			done_q    <= 1'b0;
			rd_wait_q <= 1'b0;
		end
		else
		begin
			rd_wait_q <= win_read & ~rd_wait_q;
			if (wr_ok & (sel == BASE))
				base_q <= apb_req.pwdata[`MEMSET_ADDR_BITS-1:0];
			if (wr_ok & (sel == COUNT))  // clamp to the memory depth.
				count_q <= apb_req.pwdata[`MEMSET_ADDR_BITS] ?
					{1'b1, {`MEMSET_ADDR_BITS{1'b0}}} : apb_req.pwdata[`MEMSET_ADDR_BITS:0];
			if (wr_ok & (sel == VALUE))
				value_q <= apb_req.pwdata[`MEMSET_DATA_BITS-1:0];
			if (start)
			begin
				done_q <= 1'b0;
			end
			else if (finish)
			begin
				done_q   <= 1'b1;
				result_q <= base_q;  // memset returns its pointer.
			end
		end
	end

endmodule

`default_nettype wire

/* logic/memset_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "memset_settings.svh"

module memset_top
	import memset_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  apb_req_t apb_req,
	output apb_rsp_t apb_rsp,
	output logic     fill_done
);

	logic                         start;
	logic                         busy;
	logic                         finish;
	fill_cmd_t                    cmd;
	mem_wr_t                      mem_wr;
	logic [`MEMSET_ADDR_BITS-1:0] win_addr;
	logic [`MEMSET_DATA_BITS-1:0] win_wdata;
	logic                         win_we;
	logic                         win_re;
	logic [`MEMSET_DATA_BITS-1:0] win_rdata;

	memset_apb_regs u_regs (
		.clk       (clk),
		.reset     (reset),
		.apb_req   (apb_req),
		.apb_rsp   (apb_rsp),
		.busy      (busy),
		.finish    (finish),
		.start     (start),
		.cmd       (cmd),
		.win_addr  (win_addr),
		.win_wdata (win_wdata),
		.win_we    (win_we),
		.win_re    (win_re),
		.win_rdata (win_rdata),
		.fill_done (fill_done)
	);

	fill_engine u_engine (
		.clk    (clk),
		.reset  (reset),
		.start  (start),
		.cmd    (cmd),
		.busy   (busy),
		.finish (finish),
		.mem_wr (mem_wr)
	);

	scratch_mem u_mem (
		.clk       (clk),
		.mem_wr    (mem_wr),
		.win_addr  (win_addr),
		.win_wdata (win_wdata),
		.win_we    (win_we),
		.win_re    (win_re),
		.win_rdata (win_rdata)
	);

endmodule

`default_nettype wire

/* dv/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_gen
(
	output logic clk,
	output logic reset
);

	initial
	begin
		clk   = 1'b0;
		reset = 1'b1;
		repeat (8) @(posedge clk);
		#1 reset = 1'b0;  // released just after the eighth edge.
	end

	always #50 clk = ~clk;  // 100 ns period.

endmodule

`default_nettype wire

/* dv/memset_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "memset_settings.svh"

module memset_tb
	import memset_pkg::*;
();

	logic     clk;
	logic     reset;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	logic     fill_done;

	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	int          cycle_limit = 0;  // zero until the test file is scanned.
	logic [31:0] lfsr;

	clock_gen u_clk (
		.clk   (clk),
		.reset (reset)
	);

	memset_top DUT (
		.clk       (clk),
		.reset     (reset),
		.apb_req   (apb_req),
		.apb_rsp   (apb_rsp),
		.fill_done (fill_done)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// setup cycle then access cycles until pready.
	task automatic apb_xfer(input logic wr, input logic [`APB_ADDR_BITS-1:0] addr,
			input logic [`APB_DATA_BITS-1:0] data, output apb_rsp_t rsp, output int waits);
		logic [31:0] gap;
		take_bits(2, gap);
		waits = 0;
		repeat (gap[1:0]) @(posedge clk);
		@(posedge clk);
		#1;
		apb_req.paddr   = addr;
		apb_req.pwrite  = wr;
		apb_req.pwdata  = data;
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		@(posedge clk);
		#1;
		apb_req.penable = 1'b1;
		do
		begin
			@(negedge clk);  // response is settled mid-cycle.
			rsp = apb_rsp;
			if (!rsp.pready)
				waits++;
			@(posedge clk);
		end while (!rsp.pready);
		#1;
		apb_req.psel    = 1'b0;
		apb_req.penable = 1'b0;
	endtask

	task automatic check_rsp(input apb_rsp_t rsp, input logic [`APB_ADDR_BITS-1:0] addr,
			input logic [`APB_DATA_BITS-1:0] exp_data, input logic exp_err,
			input logic data_valid, input int exp_waits, input int waits);
		checks++;
		if (rsp.pslverr !== exp_err)
		begin
			errors++;
			$display("[ERROR] pslverr at 0x%03h: expected 0x%0h, actual 0x%0h",
				addr, exp_err, rsp.pslverr);
		end
		if (data_valid && rsp.prdata !== exp_data)
		begin
			errors++;
			$display("[ERROR] prdata at 0x%03h: expected 0x%08h, actual 0x%08h",
				addr, exp_data, rsp.prdata);
		end
		if (waits != exp_waits)
		begin
			errors++;
			$display("[ERROR] pready wait states at 0x%03h: expected 0x%0h, actual 0x%0h",
				addr, exp_waits, waits);
		end
	endtask

	task automatic check_done(input logic actual, input logic expected);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("[ERROR] fill_done: expected 0x%0h, actual 0x%0h", expected, actual);
		end
	endtask

	task automatic wait_done(input int limit, input int exp_cycles);
		int n;
		n = 0;
		while (fill_done !== 1'b1 && n < limit)
		begin
			@(negedge clk);
			n++;
		end
		if (fill_done !== 1'b1)
		begin
			errors++;
			$display("fill_done did not rise within %0d cycles of waiting", limit);
		end
		else if (exp_cycles >= 0)
		begin
			checks++;
			if (n != exp_cycles)
			begin
				errors++;
				$display("[ERROR] fill_done rise cycle: expected 0x%0h, actual 0x%0h",
					exp_cycles, n);
			end
		end
	endtask

	task automatic run_fill(input logic [7:0] base, input logic [8:0] count,
			input logic [7:0] value);
		apb_rsp_t rsp;
		int       waits;
		apb_xfer(1'b1, BASE, {24'h0, base}, rsp, waits);
		check_rsp(rsp, BASE, '0, 1'b0, 1'b0, 0, waits);
		apb_xfer(1'b1, COUNT, {23'h0, count}, rsp, waits);
		check_rsp(rsp, COUNT, '0, 1'b0, 1'b0, 0, waits);
		apb_xfer(1'b1, VALUE, {24'h0, value}, rsp, waits);
		check_rsp(rsp, VALUE, '0, 1'b0, 1'b0, 0, waits);
		apb_xfer(1'b1, CTRL, 32'h1, rsp, waits);
		check_rsp(rsp, CTRL, '0, 1'b0, 1'b0, 0, waits);
		check_done(fill_done, 1'b0);  // start clears the sticky flag.
		wait_done(count + 16, count + 2);  // count writes, finish, then the flag.
	endtask

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit)
		begin
			errors++;
			$display("run stopped after reaching the limit of %0d cycles", cycle_limit);
			$display("checks: %0d, errors: %0d", checks, errors);
			$display("Finished with errors");
			$finish;
		end
	end

	initial
	begin
		int          fd;
		int          n;
		int          lines;
		int          fill_sum;
		int          waits;
		string       line;
		logic [7:0]  op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] wdata;
		apb_rsp_t    rsp;

		apb_req  = '0;
		lfsr     = 32'h1532024b;
		lines    = 0;
		fill_sum = 0;
		fd = $fopen("dv/memset_tests.txt", "r");
		if (fd == 0)
		begin
			errors++;
			$display("could not open the test file dv/memset_tests.txt");
		end
		while (fd != 0 && $fgets(line, fd) > 0)
		begin
			if (line.len() > 1 && line[0] != "#")
			begin
				lines++;
				n = $sscanf(line, "%c %h %h %h", op, a, b, c);
				if (op == "F")
					fill_sum += b;
			end
		end
		cycle_limit = fill_sum + 40 * lines;
		if (fd != 0)
		begin
			$fclose(fd);
			fd = $fopen("dv/memset_tests.txt", "r");
		end

		@(negedge reset);
		while (fd != 0 && $fgets(line, fd) > 0)
		begin
			if (line.len() > 1 && line[0] != "#")
			begin
				n = $sscanf(line, "%c %h %h %h", op, a, b, c);
				case (op)
					"W":
					begin
						apb_xfer(1'b1, a[11:0], b, rsp, waits);
						check_rsp(rsp, a[11:0], '0, 1'b0, 1'b0, 0, waits);
					end
					"R":
					begin
						apb_xfer(1'b0, a[11:0], '0, rsp, waits);
						check_rsp(rsp, a[11:0], b, 1'b0, 1'b1,
							(a[11:8] == 4'h1) ? 1 : 0, waits);  // window reads wait once.
					end
					"E":
					begin
						take_bits(8, wdata);  // errored writes carry random data.
						apb_xfer(b[0], a[11:0], wdata, rsp, waits);
						check_rsp(rsp, a[11:0], '0, 1'b1, 1'b1, 0, waits);
					end
					"F":
						run_fill(a[7:0], b[8:0], c[7:0]);
					"D":
						wait_done(`MEMSET_MEM_DEPTH + 16, -1);
					default:
					begin
						errors++;
						$display("unknown opcode in test line: %s", line);
					end
				endcase
			end
		end

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+include
logic/memset_pkg.sv
logic/scratch_mem.sv
logic/fill_engine.sv
logic/memset_apb_regs.sv
logic/memset_top.sv
dv/clock_gen.sv
dv/memset_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the memset testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f filelist.f \
	--top-module memset_tb -o memset_sim

./obj_dir/memset_sim | tee sim.log

if grep -q "Finished with no errors" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

/* dv/memset_tests.txt */
# op and hex fields: W offset data, R offset expected, E offset write(1)/read(0) expects pslverr,
# F base count value runs a fill and waits, D waits for fill_done. window is 100 to 1ff.
W 008 5a
W 00c 20
W 010 c3
R 008 5a
R 00c 20
R 010 c3
E 0fc 1
E 200 0
W 13f 11
W 148 22
F 40 8 a7
R 13f 11
R 140 a7
R 147 a7
R 148 22
R 014 40
R 004 1
W 1f7 33
W 108 44
F f8 10 5e
R 1f7 33
R 1f8 5e
R 1ff 5e
R 107 5e
R 108 44
R 014 f8
W 120 77
F 20 0 99
R 120 77
R 004 1
R 014 20
W 008 10
W 00c 100
W 010 3c
W 000 1
R 004 2
E 008 1
E 00c 1
E 000 1
E 150 1
E 150 0
R 008 10
D
R 004 1
R 014 10
R 13f 3c
R 150 3c
R 00c 100
